// ==== rtl/mipsPkg.sv ====
package mipsPkg;

    // datapath widths
    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;

    // opcodes in instruction bits 31:26
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // R-type functs in instruction bits 5:0
    localparam logic [5:0] functAdd = 6'h20;
    localparam logic [5:0] functSub = 6'h22;
    localparam logic [5:0] functAnd = 6'h24;
    localparam logic [5:0] functOr = 6'h25;
    localparam logic [5:0] functSlt = 6'h2a;

    // control states
    localparam logic [3:0] stateFetch = 4'h0;
    localparam logic [3:0] stateDecodeRegFetch = 4'h1;
    localparam logic [3:0] stateMemAddrCompute = 4'h2;
    localparam logic [3:0] stateMemRead = 4'h3;
    localparam logic [3:0] stateWriteBack = 4'h4;
    localparam logic [3:0] stateMemWrite = 4'h5;
    localparam logic [3:0] stateExecute = 4'h6;
    localparam logic [3:0] stateRTypeCompletion = 4'h7;
    localparam logic [3:0] stateBeqCompletion = 4'h8;
    localparam logic [3:0] stateJumpCompletion = 4'h9;
    localparam logic [3:0] stateBneCompletion = 4'ha;
    localparam logic [3:0] stateReset = 4'hf;

    // aluOp from the control
    localparam logic [1:0] aluOpAdd = 2'b00;
    localparam logic [1:0] aluOpSub = 2'b01;
    localparam logic [1:0] aluOpFunct = 2'b10;

    // decoded ALU operation
    localparam logic [2:0] aluCtlAdd = 3'd0;
    localparam logic [2:0] aluCtlSub = 3'd1;
    localparam logic [2:0] aluCtlAnd = 3'd2;
    localparam logic [2:0] aluCtlOr = 3'd3;
    localparam logic [2:0] aluCtlSlt = 3'd4;

    // conditional PC write
    localparam logic [1:0] pcCondNone = 2'b00;
    localparam logic [1:0] pcCondEqual = 2'b01;
    localparam logic [1:0] pcCondNotEqual = 2'b10;

    // next PC source
    localparam logic [1:0] pcSrcAluResult = 2'b00;
    localparam logic [1:0] pcSrcAluOut = 2'b01;
    localparam logic [1:0] pcSrcJump = 2'b10;

    // second ALU operand
    localparam logic [1:0] srcBRegB = 2'b00;
    localparam logic [1:0] srcBFour = 2'b01;
    localparam logic [1:0] srcBImm = 2'b10;
    localparam logic [1:0] srcBImmShifted = 2'b11;

endpackage

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [1:0]                    aluOp,
    input  logic [5:0]                    funct,
    input  logic [mipsPkg::wordWidth-1:0] a,
    input  logic [mipsPkg::wordWidth-1:0] b,
    output logic [mipsPkg::wordWidth-1:0] result,
    output logic                          zero
);

    logic [2:0] aluCtl;

    // operation decode
    always_comb begin
        case (aluOp)
            mipsPkg::aluOpSub: aluCtl = mipsPkg::aluCtlSub;
            mipsPkg::aluOpFunct: begin
                case (funct)
                    mipsPkg::functSub: aluCtl = mipsPkg::aluCtlSub;
                    mipsPkg::functAnd: aluCtl = mipsPkg::aluCtlAnd;
                    mipsPkg::functOr: aluCtl = mipsPkg::aluCtlOr;
                    mipsPkg::functSlt: aluCtl = mipsPkg::aluCtlSlt;
                    default: aluCtl = mipsPkg::aluCtlAdd;
                endcase
            end
            default: aluCtl = mipsPkg::aluCtlAdd;
        endcase
    end

    always_comb begin
        case (aluCtl)
            mipsPkg::aluCtlSub: result = a - b;
            mipsPkg::aluCtlAnd: result = a & b;
            mipsPkg::aluCtlOr: result = a | b;
            mipsPkg::aluCtlSlt: begin
                // signed compare
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [mipsPkg::regAddrWidth-1:0] rdAddr1,
    input  logic [mipsPkg::regAddrWidth-1:0] rdAddr2,
    input  logic [mipsPkg::regAddrWidth-1:0] wrAddr,
    input  logic [mipsPkg::wordWidth-1:0]    wrData,
    input  logic                             wrEn,
    output logic [mipsPkg::wordWidth-1:0]    rdData1,
    output logic [mipsPkg::wordWidth-1:0]    rdData2
);

    logic [mipsPkg::wordWidth-1:0] regs [0:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // r0 reads as zero
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

// ==== rtl/multiCycleControl.sv ====
`timescale 1ns/1ps

module multiCycleControl (
    input  logic       clk,
    input  logic       rst,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    output logic [1:0] pcWriteCond,
    output logic       pcWrite,
    output logic       iorD,
    output logic       memRead,
    output logic       memWrite,
    output logic       memToReg,
    output logic       irWrite,
    output logic [1:0] pcSource,
    output logic [1:0] aluOp,
    output logic [1:0] aluSrcB,
    output logic       aluSrcA,
    output logic       regWrite,
    output logic       regDst
);

    logic [3:0] state;
    logic [3:0] nextState;
    logic       functOk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mipsPkg::stateReset;
        end else begin
            state <= nextState;
        end
    end

    // only the listed R-type functs are run
    always_comb begin
        case (funct)
            mipsPkg::functAdd,
            mipsPkg::functSub,
            mipsPkg::functAnd,
            mipsPkg::functOr,
            mipsPkg::functSlt: functOk = 1'b1;
            default: functOk = 1'b0;
        endcase
    end

    always_comb begin
        pcWriteCond = mipsPkg::pcCondNone;
        pcWrite = 1'b0;
        iorD = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        irWrite = 1'b0;
        pcSource = mipsPkg::pcSrcAluResult;
        aluOp = mipsPkg::aluOpAdd;
        aluSrcB = mipsPkg::srcBRegB;
        aluSrcA = 1'b0;
        regWrite = 1'b0;
        regDst = 1'b0;
        nextState = mipsPkg::stateReset;

        case (state)
            mipsPkg::stateReset: begin
                nextState = mipsPkg::stateFetch;
            end
            mipsPkg::stateFetch: begin
                // IR <= mem[PC], PC <= PC + 4
                memRead = 1'b1;
                irWrite = 1'b1;
                aluSrcB = mipsPkg::srcBFour;
                pcWrite = 1'b1;
                nextState = mipsPkg::stateDecodeRegFetch;
            end
            mipsPkg::stateDecodeRegFetch: begin
                // branch target into ALUOut ahead of time
                aluSrcB = mipsPkg::srcBImmShifted;
                case (opcode)
                    mipsPkg::opLw,
                    mipsPkg::opSw: nextState = mipsPkg::stateMemAddrCompute;
                    mipsPkg::opRType: begin
                        if (functOk) begin
                            nextState = mipsPkg::stateExecute;
                        end
                    end
                    mipsPkg::opBeq: nextState = mipsPkg::stateBeqCompletion;
                    mipsPkg::opBne: nextState = mipsPkg::stateBneCompletion;
                    mipsPkg::opJ: nextState = mipsPkg::stateJumpCompletion;
                    default: nextState = mipsPkg::stateReset;
                endcase
            end
            mipsPkg::stateMemAddrCompute: begin
                aluSrcA = 1'b1;
                aluSrcB = mipsPkg::srcBImm;
                if (opcode == mipsPkg::opLw) begin
                    nextState = mipsPkg::stateMemRead;
                end else if (opcode == mipsPkg::opSw) begin
                    nextState = mipsPkg::stateMemWrite;
                end
            end
            mipsPkg::stateMemRead: begin
                memRead = 1'b1;
                iorD = 1'b1;
                nextState = mipsPkg::stateWriteBack;
            end
            mipsPkg::stateWriteBack: begin
                // rt <= MDR
                regWrite = 1'b1;
                memToReg = 1'b1;
                nextState = mipsPkg::stateFetch;
            end
            mipsPkg::stateMemWrite: begin
                memWrite = 1'b1;
                iorD = 1'b1;
                nextState = mipsPkg::stateFetch;
            end
            mipsPkg::stateExecute: begin
                aluSrcA = 1'b1;
                aluOp = mipsPkg::aluOpFunct;
                nextState = mipsPkg::stateRTypeCompletion;
            end
            mipsPkg::stateRTypeCompletion: begin
                regWrite = 1'b1;
                regDst = 1'b1;
                nextState = mipsPkg::stateFetch;
            end
            mipsPkg::stateBeqCompletion: begin
                aluSrcA = 1'b1;
                aluOp = mipsPkg::aluOpSub;
                pcWriteCond = mipsPkg::pcCondEqual;
                pcSource = mipsPkg::pcSrcAluOut;
                nextState = mipsPkg::stateFetch;
            end
            mipsPkg::stateBneCompletion: begin
                aluSrcA = 1'b1;
                aluOp = mipsPkg::aluOpSub;
                pcWriteCond = mipsPkg::pcCondNotEqual;
                pcSource = mipsPkg::pcSrcAluOut;
                nextState = mipsPkg::stateFetch;
            end
            mipsPkg::stateJumpCompletion: begin
                pcWrite = 1'b1;
                pcSource = mipsPkg::pcSrcJump;
                nextState = mipsPkg::stateFetch;
            end
            default: begin
                nextState = mipsPkg::stateReset;
            end
        endcase
    end

endmodule

// ==== rtl/mipsDatapath.sv ====
`timescale 1ns/1ps

module mipsDatapath (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [1:0]                       pcWriteCond,
    input  logic                             pcWrite,
    input  logic                             iorD,
    input  logic                             memRead,
    input  logic                             memWrite,
    input  logic                             memToReg,
    input  logic                             irWrite,
    input  logic [1:0]                       pcSource,
    input  logic [1:0]                       aluSrcB,
    input  logic                             aluSrcA,
    input  logic                             regWrite,
    input  logic                             regDst,
    output logic [5:0]                       opcode,
    output logic [5:0]                       funct,
    output logic [mipsPkg::wordWidth-1:0]    memAddr,
    output logic [mipsPkg::wordWidth-1:0]    memWdata,
    input  logic [mipsPkg::wordWidth-1:0]    memRdata,
    output logic [mipsPkg::wordWidth-1:0]    aluA,
    output logic [mipsPkg::wordWidth-1:0]    aluB,
    output logic [5:0]                       aluFunct,
    input  logic [mipsPkg::wordWidth-1:0]    aluResult,
    input  logic                             aluZero,
    output logic [mipsPkg::regAddrWidth-1:0] rdAddr1,
    output logic [mipsPkg::regAddrWidth-1:0] rdAddr2,
    output logic [mipsPkg::regAddrWidth-1:0] wrAddr,
    output logic [mipsPkg::wordWidth-1:0]    wrData,
    output logic                             wrEn,
    input  logic [mipsPkg::wordWidth-1:0]    rdData1,
    input  logic [mipsPkg::wordWidth-1:0]    rdData2
);

    logic [mipsPkg::wordWidth-1:0] pc;
    logic [mipsPkg::wordWidth-1:0] ir;
    logic [mipsPkg::wordWidth-1:0] mdr;
    logic [mipsPkg::wordWidth-1:0] regA;
    logic [mipsPkg::wordWidth-1:0] regB;
    logic [mipsPkg::wordWidth-1:0] aluOut;
    logic [mipsPkg::wordWidth-1:0] immExt;
    logic [mipsPkg::wordWidth-1:0] jumpTarget;
    logic [mipsPkg::wordWidth-1:0] pcNext;
    logic                          pcEn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (pcEn) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) begin
            ir <= memRdata;
        end
        if (memRead) begin
            mdr <= memRdata;
        end
        // operands and ALU result are sampled every cycle
        regA <= rdData1;
        regB <= rdData2;
        aluOut <= aluResult;
    end

    assign opcode = ir[31:26];
    assign funct = ir[5:0];
    assign aluFunct = ir[5:0];

    assign immExt = {{16{ir[15]}}, ir[15:0]};
    assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

    assign memAddr = iorD ? aluOut : pc;
    // bus stays quiet between stores
    assign memWdata = memWrite ? regB : '0;

    assign aluA = aluSrcA ? regA : pc;

    always_comb begin
        case (aluSrcB)
            mipsPkg::srcBRegB: aluB = regB;
            mipsPkg::srcBFour: aluB = 32'd4;
            mipsPkg::srcBImm: aluB = immExt;
            default: aluB = {immExt[29:0], 2'b00};
        endcase
    end

    always_comb begin
        case (pcSource)
            mipsPkg::pcSrcAluOut: pcNext = aluOut;
            mipsPkg::pcSrcJump: pcNext = jumpTarget;
            default: pcNext = aluResult;
        endcase
    end

    assign pcEn = pcWrite
        || (pcWriteCond == mipsPkg::pcCondEqual && aluZero)
        || (pcWriteCond == mipsPkg::pcCondNotEqual && !aluZero);

    assign rdAddr1 = ir[25:21];
    assign rdAddr2 = ir[20:16];
    assign wrAddr = regDst ? ir[15:11] : ir[20:16];
    assign wrData = memToReg ? mdr : aluOut;
    assign wrEn = regWrite;

endmodule

// ==== rtl/multiCycleCpu.sv ====
`timescale 1ns/1ps

module multiCycleCpu (
    input  logic                          clk,
    input  logic                          rst,
    output logic [mipsPkg::wordWidth-1:0] memAddr,
    output logic [mipsPkg::wordWidth-1:0] memWdata,
    output logic                          memRead,
    output logic                          memWrite,
    input  logic [mipsPkg::wordWidth-1:0] memRdata
);

    logic [5:0]                       opcode;
    logic [5:0]                       funct;
    logic [1:0]                       pcWriteCond;
    logic                             pcWrite;
    logic                             iorD;
    logic                             memToReg;
    logic                             irWrite;
    logic [1:0]                       pcSource;
    logic [1:0]                       aluOp;
    logic [1:0]                       aluSrcB;
    logic                             aluSrcA;
    logic                             regWrite;
    logic                             regDst;
    logic [mipsPkg::wordWidth-1:0]    aluA;
    logic [mipsPkg::wordWidth-1:0]    aluB;
    logic [5:0]                       aluFunct;
    logic [mipsPkg::wordWidth-1:0]    aluResult;
    logic                             aluZero;
    logic [mipsPkg::regAddrWidth-1:0] rdAddr1;
    logic [mipsPkg::regAddrWidth-1:0] rdAddr2;
    logic [mipsPkg::regAddrWidth-1:0] wrAddr;
    logic [mipsPkg::wordWidth-1:0]    wrData;
    logic                             wrEn;
    logic [mipsPkg::wordWidth-1:0]    rdData1;
    logic [mipsPkg::wordWidth-1:0]    rdData2;

    multiCycleControl i_multiCycleControl (
        .clk(clk),
        .rst(rst),
        .opcode(opcode),
        .funct(funct),
        .pcWriteCond(pcWriteCond),
        .pcWrite(pcWrite),
        .iorD(iorD),
        .memRead(memRead),
        .memWrite(memWrite),
        .memToReg(memToReg),
        .irWrite(irWrite),
        .pcSource(pcSource),
        .aluOp(aluOp),
        .aluSrcB(aluSrcB),
        .aluSrcA(aluSrcA),
        .regWrite(regWrite),
        .regDst(regDst)
    );

    mipsDatapath i_mipsDatapath (
        .clk(clk),
        .rst(rst),
        .pcWriteCond(pcWriteCond),
        .pcWrite(pcWrite),
        .iorD(iorD),
        .memRead(memRead),
        .memWrite(memWrite),
        .memToReg(memToReg),
        .irWrite(irWrite),
        .pcSource(pcSource),
        .aluSrcB(aluSrcB),
        .aluSrcA(aluSrcA),
        .regWrite(regWrite),
        .regDst(regDst),
        .opcode(opcode),
        .funct(funct),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memRdata(memRdata),
        .aluA(aluA),
        .aluB(aluB),
        .aluFunct(aluFunct),
        .aluResult(aluResult),
        .aluZero(aluZero),
        .rdAddr1(rdAddr1),
        .rdAddr2(rdAddr2),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .wrEn(wrEn),
        .rdData1(rdData1),
        .rdData2(rdData2)
    );

    alu i_alu (
        .aluOp(aluOp),
        .funct(aluFunct),
        .a(aluA),
        .b(aluB),
        .result(aluResult),
        .zero(aluZero)
    );

    registerFile i_registerFile (
        .clk(clk),
        .rst(rst),
        .rdAddr1(rdAddr1),
        .rdAddr2(rdAddr2),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .wrEn(wrEn),
        .rdData1(rdData1),
        .rdData2(rdData2)
    );

endmodule

// ==== verif/cpuRefModel.svh ====
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// program image with the data region at the top of memory
localparam int dataBase = 192;
localparam int preambleLen = 15;
localparam int bodyLen = 60;

logic [31:0] rngState;
logic [31:0] image [0:255];
logic [31:0] expFetch [$];
int          expCycles [$];
logic [31:0] expStoreAddr [$];
logic [31:0] expStoreData [$];

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                     input logic [4:0] rd, input logic [5:0] fn);
    return {mipsPkg::opRType, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [5:0] pickFunct(input int sel);
    case (sel % 5)
        0: return mipsPkg::functAdd;
        1: return mipsPkg::functSub;
        2: return mipsPkg::functAnd;
        3: return mipsPkg::functOr;
        default: return mipsPkg::functSlt;
    endcase
endfunction

function automatic void buildProgram();
    int          i;
    int          haltIdx;
    int          span;
    int          skip;
    logic [31:0] r;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] dataOff;
    rngState = 32'd45;
    // unused words decode as an unsupported opcode tagged by address
    for (i = 0; i < 256; i++) begin
        image[i] = 32'hfc000000 | 32'(i);
    end
    for (i = dataBase; i < 256; i++) begin
        image[i] = xorshift32();
    end
    // r1..r15 from the data region
    for (i = 1; i <= preambleLen; i++) begin
        image[i-1] = encI(mipsPkg::opLw, 5'd0, 5'(i), 16'((dataBase + i) * 4));
    end
    haltIdx = preambleLen + bodyLen;
    for (i = preambleLen; i < haltIdx; i++) begin
        r = xorshift32();
        rs = {1'b0, r[11:8]};
        rt = {1'b0, r[15:12]};
        rd = {1'b0, r[19:16]};
        dataOff = 16'((dataBase + int'(r[25:20])) * 4);
        // forward only and never past the halt
        span = haltIdx - i;
        skip = int'(r[23:22]) % span;
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: image[i] = encR(rs, rt, rd, pickFunct(int'(r[30:28])));
            4'd4, 4'd5: image[i] = encI(mipsPkg::opLw, 5'd0, rt, dataOff);
            4'd6, 4'd7, 4'd8: image[i] = encI(mipsPkg::opSw, 5'd0, rt, dataOff);
            4'd9, 4'd10: image[i] = encI(mipsPkg::opBeq, rs, rt, 16'(skip));
            4'd11, 4'd12: image[i] = encI(mipsPkg::opBne, rs, rt, 16'(skip));
            4'd13: image[i] = {mipsPkg::opJ, 26'(i + 1 + skip)};
            4'd14: image[i] = {6'h08, r[25:0]};
            default: image[i] = encR(rs, rt, rd, 6'h00);
        endcase
    end
    image[haltIdx] = {mipsPkg::opJ, 26'(haltIdx)};
endfunction

function automatic void runReference();
    logic [31:0] refMem [0:255];
    logic [31:0] regs [0:31];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] target;
    logic [31:0] offset;
    int          i;
    int          cyc;
    bit          halted;
    for (i = 0; i < 256; i++) begin
        refMem[i] = image[i];
    end
    for (i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    pc = '0;
    halted = 1'b0;
    for (i = 0; i < 1000 && !halted; i++) begin
        expFetch.push_back(pc);
        inst = refMem[pc[9:2]];
        pc = pc + 32'd4;
        a = regs[inst[25:21]];
        b = regs[inst[20:16]];
        offset = {{16{inst[15]}}, inst[15:0]};
        addr = a + offset;
        cyc = 3;
        case (inst[31:26])
            mipsPkg::opLw: begin
                if (inst[20:16] != 5'd0) begin
                    regs[inst[20:16]] = refMem[addr[9:2]];
                end
                cyc = 5;
            end
            mipsPkg::opSw: begin
                expStoreAddr.push_back(addr);
                expStoreData.push_back(b);
                refMem[addr[9:2]] = b;
                cyc = 4;
            end
            mipsPkg::opRType: begin
                cyc = 4;
                case (inst[5:0])
                    mipsPkg::functAdd: res = a + b;
                    mipsPkg::functSub: res = a - b;
                    mipsPkg::functAnd: res = a & b;
                    mipsPkg::functOr: res = a | b;
                    mipsPkg::functSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: cyc = 3;
                endcase
                if (cyc == 4 && inst[15:11] != 5'd0) begin
                    regs[inst[15:11]] = res;
                end
            end
            mipsPkg::opBeq: begin
                if (a == b) begin
                    pc = pc + (offset << 2);
                end
            end
            mipsPkg::opBne: begin
                if (a != b) begin
                    pc = pc + (offset << 2);
                end
            end
            mipsPkg::opJ: begin
                target = {pc[31:28], inst[25:0], 2'b00};
                halted = (target == pc - 32'd4);
                pc = target;
            end
            default: cyc = 3;
        endcase
        expCycles.push_back(cyc);
    end
    // halt fetched a second time
    expFetch.push_back(pc);
endfunction

`endif

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

    localparam int timeoutCycles = 20;

    logic        clk;
    logic        rst;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic        memRead;
    logic        memWrite;
    logic [31:0] mem [0:255];
    int          cycles;
    int          storeIdx;

    `include "cpuRefModel.svh"

    multiCycleCpu i_multiCycleCpu (
        .clk(clk),
        .rst(rst),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memRead(memRead),
        .memWrite(memWrite),
        .memRdata(memRdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory answers combinationally and stores at the edge
    assign memRdata = mem[memAddr[9:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr[9:2]] <= memWdata;
        end
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkStore();
        assert (storeIdx < expStoreAddr.size())
        else stopWithError("a store happened after all expected stores were seen");
        assert (memAddr == expStoreAddr[storeIdx])
        else stopWithError($sformatf("FAILED memAddr (store %0d): got %h expected %h",
                                     storeIdx, memAddr, expStoreAddr[storeIdx]));
        assert (memWdata == expStoreData[storeIdx])
        else stopWithError($sformatf("FAILED memWdata (store %0d): got %h expected %h",
                                     storeIdx, memWdata, expStoreData[storeIdx]));
        storeIdx++;
    endtask

    // counts falling edges up to the next fetch cycle
    task automatic waitFetch();
        int n;
        cycles = 0;
        for (n = 0; n < timeoutCycles; n++) begin
            @(negedge clk);
            cycles++;
            if (memWrite) begin
                checkStore();
            end
            if (i_multiCycleCpu.i_multiCycleControl.state == mipsPkg::stateFetch) begin
                return;
            end
        end
        stopWithError("timed out waiting for an instruction fetch");
    endtask

    initial begin
        int i;
        int fetchIdx;
        rst = 1'b1;
        cycles = 0;
        storeIdx = 0;
        buildProgram();
        runReference();
        for (i = 0; i < 256; i++) begin
            mem[i] <= image[i];
        end

        repeat (16) begin
            @(negedge clk);
            assert (!memRead && !memWrite)
            else stopWithError("memRead or memWrite was high during reset");
        end
        rst = 1'b0;

        // reset state for the cycle after release, then fetch
        waitFetch();
        assert (cycles == 1)
        else stopWithError($sformatf("FAILED cycles (first fetch): got %h expected %h",
                                     cycles, 1));

        for (fetchIdx = 0; fetchIdx < expFetch.size(); fetchIdx++) begin
            if (fetchIdx > 0) begin
                waitFetch();
                assert (cycles == expCycles[fetchIdx-1])
                else stopWithError($sformatf("FAILED cycles (pc %h): got %h expected %h",
                                             expFetch[fetchIdx-1], cycles,
                                             expCycles[fetchIdx-1]));
            end
            assert (memRead)
            else stopWithError($sformatf("FAILED memRead at fetch: got %h expected %h",
                                         memRead, 1'b1));
            assert (memAddr == expFetch[fetchIdx])
            else stopWithError($sformatf("FAILED memAddr (fetch %0d): got %h expected %h",
                                         fetchIdx, memAddr, expFetch[fetchIdx]));
        end

        if (storeIdx != expStoreAddr.size()) begin
            $display("only %0d of %0d expected stores were seen", storeIdx,
                     expStoreAddr.size());
            $display("=== FAIL ===");
            $fatal(1, "missing stores");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== multiCycleCpu.f ====
+incdir+verif
rtl/mipsPkg.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/multiCycleControl.sv
rtl/mipsDatapath.sv
rtl/multiCycleCpu.sv
verif/cpuTb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f multiCycleCpu.f --top-module multiCycleCpu

sim:
	verilator --binary --timing -f multiCycleCpu.f --top-module cpuTb -Mdir obj_dir
	./obj_dir/VcpuTb | awk '{ print } /=== PASS ===/ { p = 1 } END { exit !p }'

clean:
	rm -rf obj_dir
